// ==== common/core_pkg.sv ====
package core_pkg;

    localparam int XLEN      = 64;
    localparam int INST_LEN  = 32;
    localparam int REG_IDX_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // operand source seen by execute
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_LS,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [INST_LEN-1:0] instr;
    } id_payload_t;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [INST_LEN-1:0]  instr;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        logic [XLEN-1:0]      imm;
        alu_op_e              alu_op;
        logic                 imm_sel;
        logic                 branch;
        logic                 bne;
        logic                 we;
        logic [REG_IDX_W-1:0] rs1_idx;
        logic [REG_IDX_W-1:0] rs2_idx;
        logic [REG_IDX_W-1:0] rd_idx;
    } ex_payload_t;

    // shared by the ls and wb slots
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [INST_LEN-1:0]  instr;
        logic [XLEN-1:0]      result;
        logic [REG_IDX_W-1:0] rd_idx;
        logic                 we;
    } wb_payload_t;

endpackage

// ==== verilog/pipe_reg.sv ====
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // payload is don't-care while valid is low
    always_ff @(posedge clk) begin
        data_o <= data_i;
    end

    // a live slot never carries an unknown payload
    valid_payload_known: assert property (@(posedge clk) disable iff (rst_i)
        valid_o |-> !$isunknown(data_o));

endmodule

// ==== verilog/forward_unit.sv ====
module forward_unit import core_pkg::*; (
    input  logic [REG_IDX_W-1:0] rs1_idx_i,
    input  logic [REG_IDX_W-1:0] rs2_idx_i,
    input  logic                 ls_valid_i,
    input  logic                 ls_we_i,
    input  logic [REG_IDX_W-1:0] ls_rd_i,
    input  logic                 wb_valid_i,
    input  logic                 wb_we_i,
    input  logic [REG_IDX_W-1:0] wb_rd_i,
    output fwd_sel_e             rs1_sel_o,
    output fwd_sel_e             rs2_sel_o
);

    logic ls_live, wb_live;

    // x0 is never forwarded
    assign ls_live = ls_valid_i && ls_we_i && (ls_rd_i != '0);
    assign wb_live = wb_valid_i && wb_we_i && (wb_rd_i != '0);

    // younger producer in ls wins over wb
    function automatic fwd_sel_e pick(input logic [REG_IDX_W-1:0] idx);
        if (ls_live && ls_rd_i == idx) return FWD_LS;
        if (wb_live && wb_rd_i == idx) return FWD_WB;
        return FWD_RF;
    endfunction

    assign rs1_sel_o = pick(rs1_idx_i);
    assign rs2_sel_o = pick(rs2_idx_i);

endmodule

// ==== fetch/fetch_stage.sv ====
module fetch_stage import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC_P = RESET_PC
) (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    input  logic [XLEN-1:0] sram_rdata_i,
    input  logic            sram_data_valid_i,
    output logic [XLEN-1:0] sram_addr_o,
    output logic            sram_ren_o,
    output logic            fetch_valid_o,
    output id_payload_t     fetch_o
);

    logic [XLEN-1:0] pc_q;
    logic            ren_q;
    logic            accept;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ren_q <= 1'b0;
        end else begin
            ren_q <= 1'b1;
        end
    end

    // response is dropped when a branch redirects in the same cycle
    assign accept = ren_q && sram_data_valid_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC_P;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (accept) begin
            pc_q <= pc_q + 64'd4;
        end
    end

    assign sram_addr_o   = pc_q;
    assign sram_ren_o    = ren_q;
    assign fetch_valid_o = accept && !redirect_i;

    // 64-bit word, pick the half addressed by pc[2]
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = pc_q[2] ? sram_rdata_i[63:32] : sram_rdata_i[31:0];

endmodule

// ==== decode/reg_file.sv ====
module reg_file import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic [REG_IDX_W-1:0] rs1_idx_i,
    input  logic [REG_IDX_W-1:0] rs2_idx_i,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o,
    input  logic                 we_i,
    input  logic [REG_IDX_W-1:0] rd_idx_i,
    input  logic [XLEN-1:0]      rd_data_i,
    output logic [XLEN-1:0]      a0_o
);

    logic [XLEN-1:0] regs [32];
    logic            wr_live;

    assign wr_live = we_i && (rd_idx_i != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_idx_i] <= rd_data_i;
        end
    end

    // same-cycle write shows through to the reader
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                        (wr_live && rd_idx_i == rs1_idx_i) ? rd_data_i : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                        (wr_live && rd_idx_i == rs2_idx_i) ? rd_data_i : regs[rs2_idx_i];
    assign a0_o = regs[10];

endmodule

// ==== decode/decode_stage.sv ====
module decode_stage import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 id_valid_i,
    input  id_payload_t          id_i,
    input  logic                 wb_we_i,
    input  logic [REG_IDX_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]      wb_data_i,
    output ex_payload_t          ex_o,
    output logic [XLEN-1:0]      reg_a0_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i, imm_b, imm_u, imm;
    logic [XLEN-1:0] rs1_val, rs2_val;
    alu_op_e         alu_op;
    logic            we, branch, imm_sel;

    assign opcode = id_i.instr[6:0];
    assign funct3 = id_i.instr[14:12];

    assign imm_i = {{52{id_i.instr[31]}}, id_i.instr[31:20]};
    assign imm_b = {{51{id_i.instr[31]}}, id_i.instr[31], id_i.instr[7],
                    id_i.instr[30:25], id_i.instr[11:8], 1'b0};
    assign imm_u = {{32{id_i.instr[31]}}, id_i.instr[31:12], 12'b0};

    always_comb begin
        alu_op  = ALU_ADD;
        imm     = imm_i;
        imm_sel = 1'b0;
        we      = 1'b0;
        branch  = 1'b0;
        case (opcode)
            OP_REG: begin
                we = 1'b1;
                case (funct3)
                    3'b000:  alu_op = id_i.instr[30] ? ALU_SUB : ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: we = 1'b0;
                endcase
            end
            OP_IMM: begin
                // addi only
                imm_sel = 1'b1;
                we      = (funct3 == 3'b000);
            end
            OP_LUI: begin
                alu_op  = ALU_PASS_B;
                imm     = imm_u;
                imm_sel = 1'b1;
                we      = 1'b1;
            end
            OP_BRANCH: begin
                imm    = imm_b;
                branch = (funct3 == 3'b000) || (funct3 == 3'b001);
            end
            default: we = 1'b0;
        endcase
    end

    reg_file rf_u (
        .clk(clk), .rst_i(rst_i),
        .rs1_idx_i(id_i.instr[19:15]), .rs2_idx_i(id_i.instr[24:20]),
        .rs1_data_o(rs1_val), .rs2_data_o(rs2_val),
        .we_i(wb_we_i), .rd_idx_i(wb_rd_i), .rd_data_i(wb_data_i), .a0_o(reg_a0_o)
    );

    assign ex_o.pc      = id_i.pc;
    assign ex_o.instr   = id_i.instr;
    assign ex_o.rs1_val = rs1_val;
    assign ex_o.rs2_val = rs2_val;
    assign ex_o.imm     = imm;
    assign ex_o.alu_op  = alu_op;
    assign ex_o.imm_sel = imm_sel;
    assign ex_o.branch  = branch && id_valid_i;
    assign ex_o.bne     = funct3[0];
    assign ex_o.we      = we && id_valid_i;
    assign ex_o.rs1_idx = id_i.instr[19:15];
    assign ex_o.rs2_idx = id_i.instr[24:20];
    assign ex_o.rd_idx  = id_i.instr[11:7];

endmodule

// ==== execute/execute_stage.sv ====
module execute_stage import core_pkg::*; (
    input  logic            ex_valid_i,
    input  ex_payload_t     ex_i,
    input  fwd_sel_e        rs1_sel_i,
    input  fwd_sel_e        rs2_sel_i,
    input  logic [XLEN-1:0] ls_result_i,
    input  logic [XLEN-1:0] wb_result_i,
    output wb_payload_t     ls_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    logic [XLEN-1:0] rs1_val, rs2_val, op_b, result;
    logic            equal, taken;

    function automatic logic [XLEN-1:0] pick(input fwd_sel_e sel,
                                             input logic [XLEN-1:0] rf_val);
        case (sel)
            FWD_LS:  return ls_result_i;
            FWD_WB:  return wb_result_i;
            default: return rf_val;
        endcase
    endfunction

    assign rs1_val = pick(rs1_sel_i, ex_i.rs1_val);
    assign rs2_val = pick(rs2_sel_i, ex_i.rs2_val);
    assign op_b    = ex_i.imm_sel ? ex_i.imm : rs2_val;

    always_comb begin
        case (ex_i.alu_op)
            ALU_SUB:    result = rs1_val - op_b;
            ALU_AND:    result = rs1_val & op_b;
            ALU_OR:     result = rs1_val | op_b;
            ALU_XOR:    result = rs1_val ^ op_b;
            ALU_PASS_B: result = op_b;
            default:    result = rs1_val + op_b;
        endcase
    end

    // beq / bne resolve here
    assign equal         = (rs1_val == rs2_val);
    assign taken         = ex_i.branch && (ex_i.bne ? !equal : equal);
    assign redirect_o    = ex_valid_i && taken;
    assign redirect_pc_o = ex_i.pc + ex_i.imm;

    assign ls_o.pc     = ex_i.pc;
    assign ls_o.instr  = ex_i.instr;
    assign ls_o.result = result;
    assign ls_o.rd_idx = ex_i.rd_idx;
    assign ls_o.we     = ex_i.we;

    always_comb begin
        branch_never_writes: assert (!(ex_valid_i && ex_i.branch && ex_i.we))
            else $error("branch in the ex slot also writes a register");
    end

endmodule

// ==== verilog/core_top.sv ====
module core_top import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC_P = RESET_PC
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic [XLEN-1:0]      sram_rdata_i,
    input  logic                 sram_data_valid_i,
    output logic [XLEN-1:0]      sram_addr_o,
    output logic                 sram_ren_o,
    output logic                 commit_o,
    output logic [XLEN-1:0]      commit_pc_o,
    output logic [INST_LEN-1:0]  commit_instr_o,
    output logic [REG_IDX_W-1:0] commit_rd_o,
    output logic [XLEN-1:0]      commit_data_o,
    output logic                 commit_we_o,
    output logic [XLEN-1:0]      reg_a0_o
);

    logic            fetch_valid, id_valid, ex_valid, ls_valid, wb_valid;
    id_payload_t     fetch_pl, id_pl;
    ex_payload_t     dec_pl, ex_pl;
    wb_payload_t     exe_pl, ls_pl, wb_pl;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    fwd_sel_e        rs1_sel, rs2_sel;

    fetch_stage #(.RESET_PC_P(RESET_PC_P)) fetch_u (
        .clk(clk), .rst_i(rst_i),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .sram_rdata_i(sram_rdata_i), .sram_data_valid_i(sram_data_valid_i),
        .sram_addr_o(sram_addr_o), .sram_ren_o(sram_ren_o),
        .fetch_valid_o(fetch_valid), .fetch_o(fetch_pl)
    );

    // the taken branch squashes the two slots behind it
    pipe_reg #(.payload_t(id_payload_t)) id_reg_u (
        .clk(clk), .rst_i(rst_i), .flush_i(redirect),
        .valid_i(fetch_valid), .data_i(fetch_pl), .valid_o(id_valid), .data_o(id_pl)
    );

    decode_stage decode_u (
        .clk(clk), .rst_i(rst_i), .id_valid_i(id_valid), .id_i(id_pl),
        .wb_we_i(wb_valid & wb_pl.we), .wb_rd_i(wb_pl.rd_idx), .wb_data_i(wb_pl.result),
        .ex_o(dec_pl), .reg_a0_o(reg_a0_o)
    );

    pipe_reg #(.payload_t(ex_payload_t)) ex_reg_u (
        .clk(clk), .rst_i(rst_i), .flush_i(redirect),
        .valid_i(id_valid), .data_i(dec_pl), .valid_o(ex_valid), .data_o(ex_pl)
    );

    forward_unit fwd_u (
        .rs1_idx_i(ex_pl.rs1_idx), .rs2_idx_i(ex_pl.rs2_idx),
        .ls_valid_i(ls_valid), .ls_we_i(ls_pl.we), .ls_rd_i(ls_pl.rd_idx),
        .wb_valid_i(wb_valid), .wb_we_i(wb_pl.we), .wb_rd_i(wb_pl.rd_idx),
        .rs1_sel_o(rs1_sel), .rs2_sel_o(rs2_sel)
    );

    execute_stage execute_u (
        .ex_valid_i(ex_valid), .ex_i(ex_pl), .rs1_sel_i(rs1_sel), .rs2_sel_i(rs2_sel),
        .ls_result_i(ls_pl.result), .wb_result_i(wb_pl.result),
        .ls_o(exe_pl), .redirect_o(redirect), .redirect_pc_o(redirect_pc)
    );

    pipe_reg #(.payload_t(wb_payload_t)) ls_reg_u (
        .clk(clk), .rst_i(rst_i), .flush_i(1'b0),
        .valid_i(ex_valid), .data_i(exe_pl), .valid_o(ls_valid), .data_o(ls_pl)
    );

    // ls slot has no memory access left, it only delays by one
    pipe_reg #(.payload_t(wb_payload_t)) wb_reg_u (
        .clk(clk), .rst_i(rst_i), .flush_i(1'b0),
        .valid_i(ls_valid), .data_i(ls_pl), .valid_o(wb_valid), .data_o(wb_pl)
    );

    assign commit_o       = wb_valid;
    assign commit_pc_o    = wb_pl.pc;
    assign commit_instr_o = wb_pl.instr;
    assign commit_rd_o    = wb_pl.rd_idx;
    assign commit_data_o  = wb_pl.result;
    assign commit_we_o    = wb_pl.we;

endmodule

// ==== tests/core_checker.sv ====
module core_checker import core_pkg::*; #(
    parameter int MAX_N = 32
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 sram_ren_i,
    input  logic [XLEN-1:0]      sram_addr_i,
    input  logic                 commit_i,
    input  logic [XLEN-1:0]      commit_pc_i,
    input  logic [INST_LEN-1:0]  commit_instr_i,
    input  logic [REG_IDX_W-1:0] commit_rd_i,
    input  logic [XLEN-1:0]      commit_data_i,
    input  logic                 commit_we_i,
    input  logic [XLEN-1:0]      reg_a0_i,
    input  logic [XLEN-1:0]      boot_pc_i,
    input  logic [XLEN-1:0]      exp_pc_i    [MAX_N],
    input  logic [INST_LEN-1:0]  exp_instr_i [MAX_N],
    input  logic                 exp_wr_i    [MAX_N],
    input  logic [REG_IDX_W-1:0] exp_rd_i    [MAX_N],
    input  logic [XLEN-1:0]      exp_data_i  [MAX_N],
    input  int                   exp_n_i,
    input  logic [XLEN-1:0]      exp_a0_i,
    output logic                 done_o,
    output int                   checked_o,
    output int                   err_cnt_o
);

    int   idx = 0;
    int   errors = 0;
    logic req_seen = 1'b0;
    logic all_seen = 1'b0;

    assign done_o    = all_seen;
    assign checked_o = idx;
    assign err_cnt_o = errors;

    task automatic compare(input string name, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_commit();
        string tag;
        tag = $sformatf("commit %0d", idx);
        compare({tag, " pc"}, exp_pc_i[idx], commit_pc_i);
        compare({tag, " instr"}, 64'(exp_instr_i[idx]), 64'(commit_instr_i));
        if (exp_wr_i[idx]) begin
            compare({tag, " we"}, 64'd1, 64'(commit_we_i));
            compare({tag, " rd"}, 64'(exp_rd_i[idx]), 64'(commit_rd_i));
            compare({tag, " data"}, exp_data_i[idx], commit_data_i);
        end else if (commit_we_i && commit_rd_i != 5'd0) begin
            $display("%s wrote x%0d although it should change no register", tag, commit_rd_i);
            errors++;
        end
        idx++;
        // last writer of a0 has committed by now
        if (idx == exp_n_i) begin
            compare("final a0", exp_a0_i, reg_a0_i);
            all_seen = 1'b1;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_i) begin
            compare("reset commit_o", 64'd0, 64'(commit_i));
            compare("reset reg_a0_o", 64'd0, reg_a0_i);
        end else begin
            if (!req_seen && sram_ren_i) begin
                compare("first fetch address", boot_pc_i, sram_addr_i);
                req_seen = 1'b1;
            end
            if (idx == 0) begin
                compare("a0 before first commit", 64'd0, reg_a0_i);
            end
            if (commit_i && !all_seen) begin
                check_commit();
            end
        end
    end

endmodule

// ==== tests/tb_core.sv ====
module tb_core import core_pkg::*; ();

    localparam logic [XLEN-1:0] BOOT_PC = 64'h8000_0000;
    localparam int MAX_ROWS = 32;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic [XLEN-1:0]      sram_rdata = '0;
    logic                 sram_valid = 1'b0;
    logic [XLEN-1:0]      sram_addr;
    logic                 sram_ren;
    logic                 commit;
    logic [XLEN-1:0]      commit_pc;
    logic [INST_LEN-1:0]  commit_instr;
    logic [REG_IDX_W-1:0] commit_rd;
    logic [XLEN-1:0]      commit_data;
    logic                 commit_we;
    logic [XLEN-1:0]      reg_a0;

    // program table, one row per word in address order
    logic [31:0]          prog_instr  [MAX_ROWS];
    logic                 row_commits [MAX_ROWS];
    logic                 row_wr      [MAX_ROWS];
    logic [REG_IDX_W-1:0] row_rd      [MAX_ROWS];
    logic [XLEN-1:0]      row_data    [MAX_ROWS];
    int                   n_rows = 0;

    // commit sequence the checker walks
    logic [XLEN-1:0]      exp_pc    [MAX_ROWS];
    logic [INST_LEN-1:0]  exp_instr [MAX_ROWS];
    logic                 exp_wr    [MAX_ROWS];
    logic [REG_IDX_W-1:0] exp_rd    [MAX_ROWS];
    logic [XLEN-1:0]      exp_data  [MAX_ROWS];
    int                   n_exp = 0;
    logic [XLEN-1:0]      exp_a0 = '0;

    logic [31:0]          rng = 32'hb63191cb;
    int                   lat = 1;
    int                   wait_cnt = 0;
    logic                 done;
    int                   checked;
    int                   err_cnt;
    int                   cycles;
    logic                 failed;

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] alu_rr(input logic [2:0] funct3, input logic sub,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {sub ? 7'b0100000 : 7'b0000000, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] funct3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] instr_at(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] off;
        logic [31:0]     fold;
        off  = addr - BOOT_PC;
        fold = addr[63:32] ^ addr[31:0];
        if (addr >= BOOT_PC && off < 64'(4 * n_rows)) begin
            return prog_instr[off[6:2]];
        end
        // unmapped words carry opcode 0 and decode as a bubble
        return {fold[31:7] ^ fold[24:0], 7'b0000000};
    endfunction

    function automatic logic [XLEN-1:0] read_word(input logic [XLEN-1:0] addr);
        return {instr_at({addr[63:3], 3'b100}), instr_at({addr[63:3], 3'b000})};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic commits, input logic wr,
                           input logic [4:0] rd, input logic [XLEN-1:0] data);
        prog_instr[n_rows]  = instr;
        row_commits[n_rows] = commits;
        row_wr[n_rows]      = wr;
        row_rd[n_rows]      = rd;
        row_data[n_rows]    = data;
        n_rows++;
    endtask

    // instruction sram with 1 to 4 cycles of latency
    always @(posedge clk) begin
        #1;
        if (rst || !sram_ren) begin
            sram_valid = 1'b0;
            wait_cnt   = 0;
        end else if (sram_valid) begin
            sram_valid = 1'b0;
            wait_cnt   = 0;
            rng        = xorshift32(rng);
            lat        = 1 + int'(rng[1:0]);
        end else if (wait_cnt + 1 >= lat) begin
            sram_valid = 1'b1;
            sram_rdata = read_word(sram_addr);
        end else begin
            wait_cnt++;
        end
    end

    core_top #(.RESET_PC_P(BOOT_PC)) dut_i (
        .clk(clk), .rst_i(rst),
        .sram_rdata_i(sram_rdata), .sram_data_valid_i(sram_valid),
        .sram_addr_o(sram_addr), .sram_ren_o(sram_ren),
        .commit_o(commit), .commit_pc_o(commit_pc), .commit_instr_o(commit_instr),
        .commit_rd_o(commit_rd), .commit_data_o(commit_data), .commit_we_o(commit_we),
        .reg_a0_o(reg_a0)
    );

    core_checker #(.MAX_N(MAX_ROWS)) commit_chk (
        .clk(clk), .rst_i(rst), .sram_ren_i(sram_ren), .sram_addr_i(sram_addr),
        .commit_i(commit), .commit_pc_i(commit_pc), .commit_instr_i(commit_instr),
        .commit_rd_i(commit_rd), .commit_data_i(commit_data), .commit_we_i(commit_we),
        .reg_a0_i(reg_a0), .boot_pc_i(BOOT_PC), .exp_pc_i(exp_pc),
        .exp_instr_i(exp_instr), .exp_wr_i(exp_wr), .exp_rd_i(exp_rd),
        .exp_data_i(exp_data), .exp_n_i(n_exp), .exp_a0_i(exp_a0),
        .done_o(done), .checked_o(checked), .err_cnt_o(err_cnt)
    );

    initial begin
        add_row(addi_word(5'd1, 5'd0, 12'd5), 1'b1, 1'b1, 5'd1, 64'd5);
        add_row(addi_word(5'd2, 5'd0, 12'hffd), 1'b1, 1'b1, 5'd2, 64'hffff_ffff_ffff_fffd);
        // distances 1 and 2, then 3 through the register file
        add_row(alu_rr(3'b000, 1'b0, 5'd3, 5'd1, 5'd2), 1'b1, 1'b1, 5'd3, 64'd2);
        add_row(alu_rr(3'b000, 1'b1, 5'd4, 5'd3, 5'd1), 1'b1, 1'b1, 5'd4, 64'hffff_ffff_ffff_fffd);
        add_row(lui_word(5'd5, 20'h12345), 1'b1, 1'b1, 5'd5, 64'h0000_0000_1234_5000);
        add_row(alu_rr(3'b100, 1'b0, 5'd6, 5'd5, 5'd4), 1'b1, 1'b1, 5'd6, 64'hffff_ffff_edcb_affd);
        add_row(alu_rr(3'b110, 1'b0, 5'd7, 5'd6, 5'd1), 1'b1, 1'b1, 5'd7, 64'hffff_ffff_edcb_affd);
        add_row(alu_rr(3'b111, 1'b0, 5'd8, 5'd7, 5'd1), 1'b1, 1'b1, 5'd8, 64'd5);
        // write to x0, then read x0 right behind it
        add_row(addi_word(5'd0, 5'd1, 12'd7), 1'b1, 1'b0, 5'd0, 64'd0);
        add_row(alu_rr(3'b000, 1'b0, 5'd9, 5'd0, 5'd1), 1'b1, 1'b1, 5'd9, 64'd5);
        add_row(branch_word(3'b000, 5'd1, 5'd8, 13'd12), 1'b1, 1'b0, 5'd0, 64'd0);
        add_row(addi_word(5'd10, 5'd0, 12'd99), 1'b0, 1'b1, 5'd10, 64'd99);
        add_row(addi_word(5'd10, 5'd0, 12'd77), 1'b0, 1'b1, 5'd10, 64'd77);
        add_row(branch_word(3'b001, 5'd1, 5'd2, 13'd12), 1'b1, 1'b0, 5'd0, 64'd0);
        add_row(addi_word(5'd10, 5'd0, 12'd11), 1'b0, 1'b1, 5'd10, 64'd11);
        add_row(addi_word(5'd11, 5'd0, 12'd12), 1'b0, 1'b1, 5'd11, 64'd12);
        // not taken, falls through
        add_row(branch_word(3'b000, 5'd1, 5'd2, 13'd8), 1'b1, 1'b0, 5'd0, 64'd0);
        add_row(addi_word(5'd10, 5'd9, 12'd1), 1'b1, 1'b1, 5'd10, 64'd6);
        add_row(alu_rr(3'b000, 1'b0, 5'd10, 5'd10, 5'd4), 1'b1, 1'b1, 5'd10, 64'd3);
        // parks the core on a branch to itself
        add_row(branch_word(3'b000, 5'd0, 5'd0, 13'd0), 1'b1, 1'b0, 5'd0, 64'd0);

        for (int i = 0; i < n_rows; i++) begin
            if (row_commits[i]) begin
                exp_pc[n_exp]    = BOOT_PC + 64'(4 * i);
                exp_instr[n_exp] = prog_instr[i];
                exp_wr[n_exp]    = row_wr[i];
                exp_rd[n_exp]    = row_rd[i];
                exp_data[n_exp]  = row_data[i];
                n_exp++;
                if (row_wr[i] && row_rd[i] == 5'd10) begin
                    exp_a0 = row_data[i];
                end
            end
        end

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        for (cycles = 0; cycles < TIMEOUT_CYCLES && !done; cycles++) begin
            @(posedge clk);
        end
        failed = !done || err_cnt != 0;
        if (!done) begin
            $display("timeout: the program did not finish committing in %0d cycles", cycles);
        end
        $display("commits checked %0d of %0d, errors %0d, timeouts %0d",
                 checked, n_exp, err_cnt, done ? 0 : 1);
        if (!failed) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
common/core_pkg.sv
verilog/pipe_reg.sv
verilog/forward_unit.sv
fetch/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
verilog/core_top.sv
tests/core_checker.sv
tests/tb_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core -f sources.f -o tb_core_sim

out=$(./obj_dir/tb_core_sim) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors"
